// File: include/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// architectural register file
`define ARF_DEPTH 32
`define ARF_W 5

// reorder buffer
`define ROB_DEPTH 64
`define ROB_W 6

// allocation stops above ROB_DEPTH - ROB_MARGIN
// covers the one-cycle lag of the free-space flag plus a full bundle
`define ROB_MARGIN 4

`define XLEN 32

`endif

// File: source/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

    typedef logic [`ARF_W-1:0] arf_id_t;
    typedef logic [`ROB_W-1:0] rob_id_t;

    // alias table entry, check toggles on every rename of a register
    typedef struct packed {
        logic    check;
        rob_id_t robid;
    } rat_entry_t;

    // two slots from decode, sources 2*s and 2*s+1 belong to slot s
    typedef struct packed {
        logic [1:0]    slot_valid;
        arf_id_t [3:0] src_id;
        arf_id_t [1:0] dst_id;
    } dec_bundle_t;

    typedef struct packed {
        logic [`XLEN-1:0] data;
        logic             pending;  // value still in flight, use robid
        rob_id_t          robid;
    } src_info_t;

    typedef struct packed {
        dec_bundle_t     dec;
        src_info_t [3:0] src;
        rob_id_t [1:0]   dst_robid;
        logic [1:0]      valid;
    } ren_bundle_t;

    typedef struct packed {
        logic             w_valid;
        arf_id_t          arf_id;
        rob_id_t          rob_id;
        logic             w_check;
        logic [`XLEN-1:0] data;
    } retire_t;

    typedef enum logic {
        IDLE,
        CLEAR
    } flush_state_e;

endpackage

// File: source/spec_rat.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module spec_rat (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  rename_pkg::arf_id_t    [3:0]  raddr_i,
    output rename_pkg::rat_entry_t [3:0]  rdata_o,
    input  rename_pkg::arf_id_t    [1:0]  waddr_i,
    input  logic                   [1:0]  we_i,
    input  rename_pkg::rat_entry_t [1:0]  wdata_i
);

    import rename_pkg::*;

    rat_entry_t [`ARF_DEPTH-1:0] tbl_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tbl_q <= '0;
        end else if (flush_i) begin
            tbl_q <= '0;  // every register maps back to the ARF
        end else begin
            // slot 1 comes last so it wins on a collision
            for (int j = 0; j < 2; j++) begin
                if (we_i[j]) begin
                    tbl_q[waddr_i[j]] <= wdata_i[j];
                end
            end
        end
    end

    // plain reads, the spec table has no forwarding
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata_o[i] = tbl_q[raddr_i[i]];
        end
    end

    // x0 must stay unmapped, the top filters its writes
    a_x0_not_written: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(we_i[0] && (waddr_i[0] == '0)) && !(we_i[1] && (waddr_i[1] == '0))
    ) else $error("spec_rat: write to x0");

endmodule

// File: source/commit_rat.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module commit_rat (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          flush_i,
    input  rename_pkg::arf_id_t    [5:0]  raddr_i,
    output rename_pkg::rat_entry_t [5:0]  rdata_o,
    input  rename_pkg::arf_id_t    [1:0]  waddr_i,
    input  logic                   [1:0]  we_i,
    input  rename_pkg::rat_entry_t [1:0]  wdata_i
);

    import rename_pkg::*;

    rat_entry_t [`ARF_DEPTH-1:0] tbl_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tbl_q <= '0;
        end else if (flush_i) begin
            tbl_q <= '0;  // matches the cleared spec table
        end else begin
            for (int j = 0; j < 2; j++) begin
                if (we_i[j]) begin
                    tbl_q[waddr_i[j]] <= wdata_i[j];  // slot 1 last
                end
            end
        end
    end

    // retiring entries are visible in the same cycle
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            rdata_o[i] = tbl_q[raddr_i[i]];
            for (int j = 0; j < 2; j++) begin
                if (we_i[j] && (waddr_i[j] == raddr_i[i])) begin
                    rdata_o[i] = wdata_i[j];
                end
            end
        end
    end

endmodule

// File: source/arch_regfile.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module arch_regfile (
    input  logic                              clk,
    input  logic                              arst_n_i,
    input  rename_pkg::arf_id_t [3:0]         raddr_i,
    output logic                [3:0][`XLEN-1:0] rdata_o,
    input  rename_pkg::arf_id_t [1:0]         waddr_i,
    input  logic                [1:0]         we_i,
    input  logic                [1:0][`XLEN-1:0] wdata_i
);

    logic [`ARF_DEPTH-1:0][`XLEN-1:0] rf_q;

    // no flush here, retired values are architectural
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_q <= '0;
        end else begin
            for (int j = 0; j < 2; j++) begin
                if (we_i[j] && (waddr_i[j] != '0)) begin
                    rf_q[waddr_i[j]] <= wdata_i[j];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata_o[i] = rf_q[raddr_i[i]];
            for (int j = 0; j < 2; j++) begin
                if (we_i[j] && (waddr_i[j] == raddr_i[i])) begin
                    rdata_o[i] = wdata_i[j];  // slot 1 wins
                end
            end
            if (raddr_i[i] == '0) begin
                rdata_o[i] = '0;  // x0 hardwired
            end
        end
    end

endmodule

// File: source/rob_alloc.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module rob_alloc (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                flush_i,
    input  logic [1:0]          issue_i,
    input  logic [1:0]          retire_i,
    output rename_pkg::rob_id_t tail_o,
    output logic                avail_o
);

    import rename_pkg::*;

    logic [`ROB_W:0] cnt_q;   // one extra bit to hold a full ROB
    logic [`ROB_W:0] cnt_d;
    rob_id_t         tail_q;
    rob_id_t         tail_d;
    logic            avail_q;
    logic            avail_d;
    logic [1:0]      n_issue;
    logic [1:0]      n_retire;

    assign n_issue  = {1'b0, issue_i[0]} + {1'b0, issue_i[1]};
    assign n_retire = {1'b0, retire_i[0]} + {1'b0, retire_i[1]};

    assign cnt_d  = cnt_q + {{(`ROB_W-1){1'b0}}, n_issue} - {{(`ROB_W-1){1'b0}}, n_retire};
    assign tail_d = tail_q + {{(`ROB_W-2){1'b0}}, n_issue};  // wraps at ROB_DEPTH

    // looks at the old count, hence the margin
    assign avail_d = (cnt_q <= (`ROB_DEPTH - `ROB_MARGIN));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q   <= '0;
            tail_q  <= '0;
            avail_q <= 1'b1;
        end else if (flush_i) begin
            cnt_q   <= '0;
            tail_q  <= '0;
            avail_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            tail_q  <= tail_d;
            avail_q <= avail_d;
        end
    end

    assign tail_o  = tail_q;
    assign avail_o = avail_q;

    // the lagging flag must still stop allocation in time
    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cnt_q <= `ROB_DEPTH
    ) else $error("rob_alloc: occupancy above ROB depth");

    a_retire_le_occ: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !flush_i |-> ({{(`ROB_W-1){1'b0}}, n_retire} <= cnt_q)
    ) else $error("rob_alloc: retire of unallocated slot");

endmodule

// File: source/rename_stage.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module rename_stage (
    input  logic                        clk,
    input  logic                        arst_n_i,
    // decode side
    input  logic                        dec_valid_i,
    output logic                        dec_ready_o,
    input  rename_pkg::dec_bundle_t     dec_bundle_i,
    // issue side
    output logic                        iss_valid_o,
    input  logic                        iss_ready_i,
    output rename_pkg::ren_bundle_t     iss_bundle_o,
    // commit side
    input  logic [1:0]                  retire_i,
    input  rename_pkg::retire_t [1:0]   retire_info_i,
    input  logic                        flush_i,
    output logic                        flush_ack_o
);

    import rename_pkg::*;

    logic                   avail;
    rob_id_t                tail;
    logic [1:0]             issue;
    logic [1:0]             spec_we;
    logic [1:0]             ret_we;
    arf_id_t [1:0]          ret_addr;
    rob_id_t [1:0]          dst_robid;
    rat_entry_t [3:0]       spec_src;
    rat_entry_t [3:0]       cmt_src;
    rat_entry_t [1:0]       cmt_dst;
    rat_entry_t [1:0]       spec_new;
    rat_entry_t [1:0]       cmt_new;
    logic [1:0][`XLEN-1:0]  ret_data;
    logic [3:0][`XLEN-1:0]  src_data;
    flush_state_e           flush_state_q;

    assign dec_ready_o = avail & ~flush_i & iss_ready_i;
    assign iss_valid_o = dec_valid_i & avail & ~flush_i;

    // both handshakes fire together
    assign issue = dec_bundle_i.slot_valid & {2{dec_valid_i & dec_ready_o}};

    assign dst_robid[0] = tail;
    assign dst_robid[1] = issue[0] ? tail + rob_id_t'(1) : tail;

    assign spec_we = issue & {(|dec_bundle_i.dst_id[1]), (|dec_bundle_i.dst_id[0])};

    for (genvar s = 0; s < 2; s++) begin : g_slot
        assign spec_new[s].check = ~cmt_dst[s].check;  // differs from commit until retire
        assign spec_new[s].robid = dst_robid[s];

        assign ret_we[s]        = retire_i[s] & retire_info_i[s].w_valid
                                  & (|retire_info_i[s].arf_id);
        assign ret_addr[s]      = retire_info_i[s].arf_id;
        assign ret_data[s]      = retire_info_i[s].data;
        assign cmt_new[s].check = retire_info_i[s].w_check;
        assign cmt_new[s].robid = retire_info_i[s].rob_id;
    end

    spec_rat u_spec_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .raddr_i  (dec_bundle_i.src_id),
        .rdata_o  (spec_src),
        .waddr_i  (dec_bundle_i.dst_id),
        .we_i     (spec_we),
        .wdata_i  (spec_new)
    );

    commit_rat u_commit_rat (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .raddr_i  ({dec_bundle_i.dst_id, dec_bundle_i.src_id}),
        .rdata_o  ({cmt_dst, cmt_src}),
        .waddr_i  (ret_addr),
        .we_i     (ret_we),
        .wdata_i  (cmt_new)
    );

    arch_regfile u_arch_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr_i  (dec_bundle_i.src_id),
        .rdata_o  (src_data),
        .waddr_i  (ret_addr),
        .we_i     (ret_we),
        .wdata_i  (ret_data)
    );

    rob_alloc u_rob_alloc (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .flush_i  (flush_i),
        .issue_i  (issue),
        .retire_i (retire_i),
        .tail_o   (tail),
        .avail_o  (avail)
    );

    always_comb begin
        iss_bundle_o.dec       = dec_bundle_i;
        iss_bundle_o.dst_robid = dst_robid;
        iss_bundle_o.valid     = dec_bundle_i.slot_valid & {2{iss_valid_o}};
        for (int i = 0; i < 4; i++) begin
            iss_bundle_o.src[i].data    = src_data[i];
            iss_bundle_o.src[i].robid   = spec_src[i].robid;
            iss_bundle_o.src[i].pending = (spec_src[i].check != cmt_src[i].check)
                                          && (dec_bundle_i.src_id[i] != '0);
        end
    end

    // one-cycle ack after the flush pulse
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            flush_state_q <= IDLE;
        end else if (flush_i) begin
            flush_state_q <= CLEAR;
        end else begin
            flush_state_q <= IDLE;
        end
    end

    assign flush_ack_o = (flush_state_q == CLEAR);

    // nothing issues under flush
    a_flush_no_issue: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        flush_i |-> (issue == '0)
    ) else $error("rename_stage: issue during flush");

endmodule

// File: testbench/tb_rename_stage.sv
`timescale 1ns/100ps
`include "rename_defines.svh"

module tb_rename_stage;

    import rename_pkg::*;

    typedef struct packed {
        logic            dec_valid;
        dec_bundle_t     bundle;
        logic            iss_ready;
        logic [1:0]      retire;
        retire_t [1:0]   rinfo;
        logic            flush;
        logic            exp_ready;
        logic            exp_iss_valid;
        logic            exp_ack;
    } stim_t;

    logic                clk;
    logic                arst_n_i;
    logic                dec_valid_i;
    logic                dec_ready_o;
    dec_bundle_t         dec_bundle_i;
    logic                iss_valid_o;
    logic                iss_ready_i;
    ren_bundle_t         iss_bundle_o;
    logic [1:0]          retire_i;
    retire_t [1:0]       retire_info_i;
    logic                flush_i;
    logic                flush_ack_o;

    stim_t               stim_tbl[$];
    logic [15:0]         lfsr_state;
    int                  cycle_cnt;
    int                  cycle_limit;

    // table builder occupancy model
    int                  b_cnt;
    logic                b_avail;
    logic                b_flush_q;

    // reference tables
    rat_entry_t          m_spec [`ARF_DEPTH];
    rat_entry_t          m_cmt [`ARF_DEPTH];
    logic [`XLEN-1:0]    m_rf [`ARF_DEPTH];
    rob_id_t             m_tail;

    rename_stage u_rename_stage (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .dec_valid_i   (dec_valid_i),
        .dec_ready_o   (dec_ready_o),
        .dec_bundle_i  (dec_bundle_i),
        .iss_valid_o   (iss_valid_o),
        .iss_ready_i   (iss_ready_i),
        .iss_bundle_o  (iss_bundle_o),
        .retire_i      (retire_i),
        .retire_info_i (retire_info_i),
        .flush_i       (flush_i),
        .flush_ack_o   (flush_ack_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_with_failure($sformatf("timeout: run did not finish within %0d cycles",
                                        cycle_limit));
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic arf_id_t draw_reg();
        arf_id_t r;
        r = '0;
        for (int b = 0; b < `ARF_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[`ARF_W-2:0], lfsr_state[0]};  // one step per bit
        end
        return r;
    endfunction

    function automatic dec_bundle_t make_bundle(input logic [1:0] sv, input arf_id_t s0,
                                                input arf_id_t s1, input arf_id_t s2,
                                                input arf_id_t s3, input arf_id_t d0,
                                                input arf_id_t d1);
        dec_bundle_t b;
        b.slot_valid = sv;
        b.src_id[0]  = s0;
        b.src_id[1]  = s1;
        b.src_id[2]  = s2;
        b.src_id[3]  = s3;
        b.dst_id[0]  = d0;
        b.dst_id[1]  = d1;
        return b;
    endfunction

    function automatic retire_t make_retire(input logic wv, input arf_id_t r, input rob_id_t id,
                                            input logic chk, input logic [`XLEN-1:0] d);
        retire_t t;
        t.w_valid = wv;
        t.arf_id  = r;
        t.rob_id  = id;
        t.w_check = chk;
        t.data    = d;
        return t;
    endfunction

    function automatic stim_t idle_entry();
        stim_t e;
        e = '0;
        e.iss_ready = 1'b1;
        return e;
    endfunction

    task automatic random_bundle(output dec_bundle_t b);
        b.slot_valid = 2'b11;
        for (int i = 0; i < 4; i++) begin
            b.src_id[i] = draw_reg();
        end
        for (int j = 0; j < 2; j++) begin
            b.dst_id[j] = draw_reg();
        end
    endtask

    // fills in the expected handshake from the lagging free-space flag
    task automatic push_entry(input stim_t e);
        int n_iss;
        int n_ret;
        e.exp_ready     = b_avail & ~e.flush & e.iss_ready;
        e.exp_iss_valid = e.dec_valid & b_avail & ~e.flush;
        e.exp_ack       = b_flush_q;
        n_iss = (e.dec_valid && e.exp_ready) ?
                (int'(e.bundle.slot_valid[0]) + int'(e.bundle.slot_valid[1])) : 0;
        n_ret = int'(e.retire[0]) + int'(e.retire[1]);
        if (e.flush) begin
            b_cnt   = 0;
            b_avail = 1'b1;
        end else begin
            b_avail = (b_cnt <= (`ROB_DEPTH - `ROB_MARGIN));
            b_cnt   = b_cnt + n_iss - n_ret;
        end
        b_flush_q = e.flush;
        stim_tbl.push_back(e);
    endtask

    task automatic build_table();
        stim_t e;
        e = idle_entry();  // clean state, ids 0 and 1, x0 dest
        e.dec_valid = 1'b1;
        e.bundle    = make_bundle(2'b11, 1, 2, 3, 4, 7, 0);
        push_entry(e);
        e.bundle    = make_bundle(2'b01, 7, 0, 5, 0, 5, 0);
        push_entry(e);
        e.bundle    = make_bundle(2'b01, 5, 0, 0, 0, 5, 0);  // second rename of r5
        push_entry(e);
        e.bundle    = make_bundle(2'b01, 5, 7, 0, 0, 0, 0);
        e.retire    = 2'b11;
        e.rinfo[0]  = make_retire(1'b1, 7, 0, 1'b1, 32'hcafe_0007);
        e.rinfo[1]  = make_retire(1'b1, 5, 2, 1'b0, 32'h0000_0055);  // stale check
        push_entry(e);
        e = idle_entry();
        e.bundle    = make_bundle(2'b11, 7, 5, 0, 5, 0, 0);
        push_entry(e);
        e.dec_valid = 1'b1;
        e.iss_ready = 1'b0;  // back-pressure
        e.bundle    = make_bundle(2'b11, 5, 7, 1, 2, 9, 10);
        push_entry(e);
        for (int n = 0; n < 32; n++) begin  // run the ROB up to the margin
            e = idle_entry();
            e.dec_valid = 1'b1;
            random_bundle(e.bundle);
            push_entry(e);
        end
        for (int n = 0; n < 4; n++) begin  // drain until ready returns
            e = idle_entry();
            e.dec_valid = 1'b1;
            random_bundle(e.bundle);
            e.retire    = 2'b11;
            e.rinfo[0]  = make_retire(n == 0, 0, 0, 1'b1, 32'hdead_beef);
            push_entry(e);
        end
        e = idle_entry();
        e.dec_valid = 1'b1;
        e.flush     = 1'b1;
        e.bundle    = make_bundle(2'b11, 5, 7, 9, 10, 3, 4);
        push_entry(e);
        e.flush     = 1'b0;
        e.bundle    = make_bundle(2'b11, 5, 7, 9, 10, 5, 7);
        push_entry(e);
        e.bundle    = make_bundle(2'b01, 5, 0, 7, 0, 0, 0);
        push_entry(e);
    endtask

    task automatic drive_entry(input stim_t e);
        dec_valid_i   = e.dec_valid;
        dec_bundle_i  = e.bundle;
        iss_ready_i   = e.iss_ready;
        retire_i      = e.retire;
        retire_info_i = e.rinfo;
        flush_i       = e.flush;
    endtask

    // expected outputs for this cycle, then the table updates at the edge
    task automatic model_cycle(input stim_t e, output ren_bundle_t exp_b);
        logic [1:0] iss;
        arf_id_t    r;
        iss = e.bundle.slot_valid & {2{e.dec_valid & e.exp_ready}};
        for (int j = 0; j < 2; j++) begin
            r = e.rinfo[j].arf_id;
            if (e.retire[j] && e.rinfo[j].w_valid && (r != '0)) begin
                m_cmt[r].check = e.rinfo[j].w_check;
                m_cmt[r].robid = e.rinfo[j].rob_id;
                m_rf[r]        = e.rinfo[j].data;
            end
        end
        exp_b.dec          = e.bundle;
        exp_b.valid        = e.bundle.slot_valid & {2{e.exp_iss_valid}};
        exp_b.dst_robid[0] = m_tail;
        exp_b.dst_robid[1] = iss[0] ? m_tail + rob_id_t'(1) : m_tail;
        for (int i = 0; i < 4; i++) begin
            r = e.bundle.src_id[i];
            exp_b.src[i].data    = (r == '0) ? '0 : m_rf[r];
            exp_b.src[i].robid   = m_spec[r].robid;
            exp_b.src[i].pending = (r != '0) && (m_spec[r].check != m_cmt[r].check);
        end
        for (int j = 0; j < 2; j++) begin
            r = e.bundle.dst_id[j];
            if (iss[j] && (r != '0)) begin
                m_spec[r].check = ~m_cmt[r].check;
                m_spec[r].robid = exp_b.dst_robid[j];
            end
        end
        m_tail = m_tail + rob_id_t'(iss[0]) + rob_id_t'(iss[1]);
        if (e.flush) begin
            for (int k = 0; k < `ARF_DEPTH; k++) begin
                m_spec[k] = '0;
                m_cmt[k]  = '0;
            end
            m_tail = '0;
        end
    endtask

    task automatic check_bundle(input ren_bundle_t got, input ren_bundle_t exp, input int idx);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: entry %0d issue bundle %h, expected %h",
                                        $time, idx, got, exp));
        end
    endtask

    task automatic check_handshake(input logic [2:0] got, input logic [2:0] exp, input int idx);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: entry %0d ready/valid/ack %b, expected %b",
                                        $time, idx, got, exp));
        end
    endtask

    initial begin
        stim_t       e;
        ren_bundle_t exp_b;
        arst_n_i      = 1'b0;
        dec_valid_i   = 1'b0;
        dec_bundle_i  = '0;
        iss_ready_i   = 1'b1;
        retire_i      = '0;
        retire_info_i = '0;
        flush_i       = 1'b0;
        cycle_cnt     = 0;
        lfsr_state    = 16'd57231;
        b_cnt         = 0;
        b_avail       = 1'b1;
        b_flush_q     = 1'b0;
        m_tail        = '0;
        for (int k = 0; k < `ARF_DEPTH; k++) begin
            m_spec[k] = '0;
            m_cmt[k]  = '0;
            m_rf[k]   = '0;
        end
        build_table();
        cycle_limit = stim_tbl.size() + 20;

        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        for (int k = 0; k < stim_tbl.size(); k++) begin
            e = stim_tbl[k];
            drive_entry(e);
            #2;  // outputs settled, well before the next edge
            model_cycle(e, exp_b);
            check_bundle(iss_bundle_o, exp_b, k);
            check_handshake({dec_ready_o, iss_valid_o, flush_ack_o},
                            {e.exp_ready, e.exp_iss_valid, e.exp_ack}, k);
            @(posedge clk);
            #1;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
source/rename_pkg.sv
source/spec_rat.sv
source/commit_rat.sv
source/arch_regfile.sv
source/rob_alloc.sv
source/rename_stage.sv
testbench/tb_rename_stage.sv

// File: Bender.yml
package:
  name: rename_stage

export_include_dirs:
  - include

sources:
  - files:
      - source/rename_pkg.sv
      - source/spec_rat.sv
      - source/commit_rat.sv
      - source/arch_regfile.sv
      - source/rob_alloc.sv
      - source/rename_stage.sv
  - target: test
    files:
      - testbench/tb_rename_stage.sv
